// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trigger_serdes_tb \
	-f trigger_serdes_top.f -o sim_trigger_serdes > build.log 2>&1 \
	&& ./obj_dir/sim_trigger_serdes +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: src/bit_serializer.sv
`default_nettype none

module bit_serializer import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input serial_word_t buf_word, // word from the fifo
	input wire logic buf_valid,
	output logic buf_ready,
	output logic serial_out, // one bit per clock, msb first
	output logic frame_strobe, // high on the first bit of each word
	output logic [WORD_WIDTH-1:0] led_byte // word now on the line
);

	logic [WORD_WIDTH-1:0] shift_reg; // msb is the bit on the line
	logic [BIT_INDEX_WIDTH-1:0] bit_count; // position within the frame
	logic busy; // a word is being shifted
	logic last_bit; // final bit of the frame is on the line
	logic load; // take a new word at this edge

	assign last_bit = busy && (bit_count == LAST_BIT);

	// ready while idle, or on the last bit so the next frame follows with no gap
	assign buf_ready = !busy || last_bit;
	assign load = buf_valid && buf_ready;

	// line and strobe are low whenever nothing is being shifted
	assign serial_out = busy && shift_reg[WORD_WIDTH-1];
	assign frame_strobe = busy && (bit_count == '0);

	// frame control
	always_ff @(posedge clock) begin
		if (reset1) begin
			busy <= 1'b0;
			bit_count <= '0;
		end else if (load) begin
			busy <= 1'b1; // first bit goes out next cycle
			bit_count <= '0;
		end else if (last_bit) begin
			busy <= 1'b0; // nothing waiting, go idle
			bit_count <= '0;
		end else if (busy) begin
			bit_count <= bit_count + BIT_INDEX_WIDTH'(1);
		end
	end

	// shift register, payload only
	always_ff @(posedge clock) begin
		if (load) begin
			shift_reg <= buf_word.data;
		end else if (busy) begin
			shift_reg <= {shift_reg[WORD_WIDTH-2:0], 1'b0}; // next bit into msb
		end
	end

	// led bus follows the frame on the line, zero when idle
	always_ff @(posedge clock) begin
		if (reset1) begin
			led_byte <= '0;
		end else if (load) begin
			led_byte <= buf_word.data; // valid for the whole frame
		end else if (last_bit) begin
			led_byte <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/trigger_serdes_pkg.sv
`default_nettype none

package trigger_serdes_pkg;

	// serial word geometry
	localparam int WORD_WIDTH = 8; // bits shifted out per frame
	localparam int COUNT_WIDTH = 4; // running count in the low part of the word

	// source startup hold
	localparam int STARTUP_CYCLES = 16; // clocks of silence after reset release
	localparam int HOLD_WIDTH = $clog2(STARTUP_CYCLES + 1); // must reach STARTUP_CYCLES

	// buffer between source and serializer
	localparam int FIFO_DEPTH = 4; // power of two, pointers wrap naturally
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH); // index into the storage
	localparam int FIFO_PTR_WIDTH = FIFO_ADDR_WIDTH + 1; // extra bit tells full from empty

	// serializer bit position
	localparam int BIT_INDEX_WIDTH = $clog2(WORD_WIDTH); // 0 .. WORD_WIDTH-1

	// word handed from stage to stage
	typedef struct packed {
		logic [WORD_WIDTH-1:0] data; // word to send, msb goes out first
		logic seq_wrap; // count just rolled back to zero
	} serial_word_t;

	// upper bits of the word are always zero
	localparam int PAD_WIDTH = WORD_WIDTH - COUNT_WIDTH;

	// all ones count, the value just before rollover
	localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = {COUNT_WIDTH{1'b1}};

	// index of the last bit of a frame
	localparam logic [BIT_INDEX_WIDTH-1:0] LAST_BIT = BIT_INDEX_WIDTH'(WORD_WIDTH - 1);

endpackage

`default_nettype wire

// File: src/trigger_serdes_top.sv
`default_nettype none

module trigger_serdes_top import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input wire logic enable, // pauses the word source
	output logic serial_out, // serial trigger line
	output logic frame_strobe, // first bit of each word
	output logic [WORD_WIDTH-1:0] led_byte // word being sent
);

	serial_word_t src_word; // source -> fifo
	logic src_valid;
	logic src_ready;
	serial_word_t buf_word; // fifo -> serializer
	logic buf_valid;
	logic buf_ready;

	// count words after the startup hold
	word_source source0 (
		.clock(clock),
		.reset1(reset1),
		.enable(enable),
		.src_word(src_word),
		.src_valid(src_valid),
		.src_ready(src_ready)
	);

	// absorbs pauses on the serial side
	word_fifo fifo0 (
		.clock(clock),
		.reset1(reset1),
		.src_word(src_word),
		.src_valid(src_valid),
		.src_ready(src_ready),
		.buf_word(buf_word),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready)
	);

	// parallel to serial
	bit_serializer serializer0 (
		.clock(clock),
		.reset1(reset1),
		.buf_word(buf_word),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready),
		.serial_out(serial_out),
		.frame_strobe(frame_strobe),
		.led_byte(led_byte)
	);

endmodule

`default_nettype wire

// File: src/word_fifo.sv
`default_nettype none

module word_fifo import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input serial_word_t src_word, // write side
	input wire logic src_valid,
	output logic src_ready,
	output serial_word_t buf_word, // read side
	output logic buf_valid,
	input wire logic buf_ready
);

	serial_word_t mem [FIFO_DEPTH]; // storage
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr; // next slot to write with the lap bit as msb
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr; // oldest slot still held
	logic [FIFO_ADDR_WIDTH-1:0] wr_addr; // index part of wr_ptr
	logic [FIFO_ADDR_WIDTH-1:0] rd_addr; // index part of rd_ptr
	logic full; // every slot occupied
	logic empty; // nothing to read
	logic wr_en; // write accepted this cycle
	logic rd_en; // read accepted this cycle

	assign wr_addr = wr_ptr[FIFO_ADDR_WIDTH-1:0];
	assign rd_addr = rd_ptr[FIFO_ADDR_WIDTH-1:0];

	// same index on a different lap means full and identical pointers mean empty
	assign full = (wr_addr == rd_addr) &&
		(wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]);
	assign empty = (wr_ptr == rd_ptr);

	// handshake outputs come straight from the fifo state
	assign src_ready = !full; // back-pressure only when full
	assign buf_valid = !empty; // a word written at an edge shows up next cycle

	assign wr_en = src_valid && src_ready;
	assign rd_en = buf_valid && buf_ready;

	// head of the queue stays put until it is read
	assign buf_word = mem[rd_addr];

	// payload write
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= src_word;
		end
	end

	// write pointer
	always_ff @(posedge clock) begin
		if (reset1) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + FIFO_PTR_WIDTH'(1); // rolls over with the lap bit
		end
	end

	// read pointer may move in the same cycle as a write
	always_ff @(posedge clock) begin
		if (reset1) begin
			rd_ptr <= '0;
		end else if (rd_en) begin
			rd_ptr <= rd_ptr + FIFO_PTR_WIDTH'(1);
		end
	end

endmodule

`default_nettype wire

// File: src/word_source.sv
`default_nettype none

module word_source import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input wire logic enable, // low pauses new offers
	output serial_word_t src_word,
	output logic src_valid,
	input wire logic src_ready
);

	logic [HOLD_WIDTH-1:0] hold_count; // startup hold, saturates
	logic hold_done; // startup hold has run out
	logic [COUNT_WIDTH-1:0] count; // count carried by the offered word
	logic wrap_pending; // offered word is the first after a rollover
	logic transfer; // word accepted by the fifo this cycle

	assign hold_done = (hold_count == HOLD_WIDTH'(STARTUP_CYCLES));
	assign transfer = src_valid && src_ready;

	// startup hold counter
	// first edge with reset1 low takes it 0 -> 1, so it is done after STARTUP_CYCLES edges
	always_ff @(posedge clock) begin
		if (reset1) begin
			hold_count <= '0;
		end else if (!hold_done) begin
			hold_count <= hold_count + HOLD_WIDTH'(1); // stops at STARTUP_CYCLES
		end
	end

	// valid goes high the edge after the hold ends
	// a pending offer is never withdrawn, only replaced after a transfer
	always_ff @(posedge clock) begin
		if (reset1) begin
			src_valid <= 1'b0;
		end else if (!src_valid || src_ready) begin
			src_valid <= hold_done && enable; // next word only while enabled
		end
	end

	// count and wrap flag only move on a transfer, so the offered word holds still
	always_ff @(posedge clock) begin
		if (reset1) begin
			count <= '0;
			wrap_pending <= 1'b0; // first word after reset is not a rollover
		end else if (transfer) begin
			count <= count + COUNT_WIDTH'(1); // wraps after COUNT_MAX
			wrap_pending <= (count == COUNT_MAX); // next word is count zero again
		end
	end

	// pad the high part with zeros
	assign src_word.data = {{PAD_WIDTH{1'b0}}, count};
	assign src_word.seq_wrap = wrap_pending;

endmodule

`default_nettype wire

// File: trigger_serdes_top.f
src/trigger_serdes_pkg.sv
src/word_source.sv
src/word_fifo.sv
src/bit_serializer.sv
src/trigger_serdes_top.sv
verification/trigger_serdes_asserts.sv
verification/stream_checker.sv
verification/trigger_serdes_tb.sv

// File: verification/stream_checker.sv
`default_nettype none

module stream_checker import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input wire logic serial_out,
	input wire logic frame_strobe,
	input wire logic [WORD_WIDTH-1:0] led_byte,
	input wire logic words_waiting, // fifo holds a word for the serializer
	output int value_errors,
	output int protocol_errors,
	output int words_seen,
	output logic line_idle // no frame on the line and nothing queued
);

	// strobe launched STARTUP_CYCLES+2 edges after the first low edge, sampled one edge later
	localparam int FIRST_FRAME_EDGE = STARTUP_CYCLES + 4;

	int low_edges = 0; // edges seen with reset1 low, this one included
	int bit_pos = 0; // bits of the current word collected, 0 between words
	bit seen_first = 1'b0;
	bit expect_start = 1'b0; // serializer could take a waiting word at the last edge
	logic [COUNT_WIDTH-1:0] expected_count = '0; // next count due on the line
	logic [WORD_WIDTH-1:0] expected_word = '0;
	logic [WORD_WIDTH-1:0] rebuilt = '0; // serial bits, msb first

	assign line_idle = seen_first && (bit_pos == 0) && !words_waiting && !expect_start;

	task automatic report_mismatch(input string signal_name, input logic [31:0] expected,
		input logic [31:0] actual);
		value_errors++;
		$display("** Error at time %0t: %s expected %0d, got %0d", $time, signal_name,
			expected, actual);
	endtask

	task automatic report_protocol(input string what);
		protocol_errors++;
		$display("protocol failure at time %0t: %s", $time, what);
	endtask

	// samples are the values of the cycle that ends at this edge
	always @(posedge clock) begin
		if (reset1) begin
			value_errors = 0;
			protocol_errors = 0;
			words_seen = 0;
			low_edges = 0;
			bit_pos = 0;
			seen_first = 1'b0;
			expect_start = 1'b0;
			expected_count = '0; // sequence restarts at zero
		end else begin
			low_edges++;
			if (frame_strobe) begin
				if (bit_pos != 0)
					report_protocol("frame_strobe arrived in the middle of a word");
				else if (!expect_start)
					report_protocol("frame started although no word was waiting");
				if (!seen_first && low_edges != FIRST_FRAME_EDGE)
					report_mismatch("first frame_strobe edge", 32'(FIRST_FRAME_EDGE),
						32'(low_edges));
				seen_first = 1'b1;
				expected_word = WORD_WIDTH'(expected_count); // high part always zero
				rebuilt = '0;
				bit_pos = 0;
			end else if (expect_start) begin
				report_protocol("gap before the next frame while a word was waiting");
			end
			if (frame_strobe || bit_pos != 0) begin
				rebuilt = {rebuilt[WORD_WIDTH-2:0], serial_out}; // msb arrived first
				if (led_byte !== expected_word)
					report_mismatch("led_byte", 32'(expected_word), 32'(led_byte));
				bit_pos++;
				if (bit_pos == WORD_WIDTH) begin
					if (rebuilt !== expected_word)
						report_mismatch("serial word", 32'(expected_word), 32'(rebuilt));
					expected_count = expected_count + COUNT_WIDTH'(1); // wraps after 15
					words_seen++;
					bit_pos = 0;
				end
			end else begin
				if (serial_out !== 1'b0)
					report_mismatch("serial_out", 32'd0, 32'(serial_out)); // idle line
				if (led_byte !== '0)
					report_mismatch("led_byte", 32'd0, 32'(led_byte));
			end
			// idle or last bit with a word queued, so the next sample starts a frame
			expect_start = (words_waiting === 1'b1) && (bit_pos == 0);
		end
	end

endmodule

`default_nettype wire

// File: verification/trigger_serdes_asserts.sv
`default_nettype none

module trigger_serdes_asserts import trigger_serdes_pkg::*; (
	input wire logic clock,
	input wire logic reset1,
	input wire logic src_valid, // write side handshake
	input wire logic src_ready,
	input wire serial_word_t buf_word,
	input wire logic buf_valid,
	input wire logic buf_ready
);

	int failures = 0; // assertion failures so far
	logic [FIFO_PTR_WIDTH-1:0] fill_level; // words held, rebuilt from the handshakes
	logic zero_read; // a count zero word has already left the fifo
	logic wr_taken; // write accepted at this edge
	logic rd_taken; // read accepted at this edge

	assign wr_taken = src_valid && src_ready;
	assign rd_taken = buf_valid && buf_ready;

	// reference occupancy and wrap history
	always_ff @(posedge clock) begin
		if (reset1) begin
			fill_level <= '0;
			zero_read <= 1'b0;
		end else begin
			fill_level <= fill_level + FIFO_PTR_WIDTH'(wr_taken) - FIFO_PTR_WIDTH'(rd_taken);
			if (rd_taken && buf_word.data == '0)
				zero_read <= 1'b1;
		end
	end

	// a full fifo must refuse the write
	no_write_when_full: assert property (@(posedge clock) disable iff (reset1)
		(fill_level == FIFO_PTR_WIDTH'(FIFO_DEPTH)) |-> !wr_taken)
		else begin
			failures++;
			$error("fifo accepted a write while full");
		end

	// nothing to offer when empty
	no_valid_when_empty: assert property (@(posedge clock) disable iff (reset1)
		(fill_level == '0) |-> !buf_valid)
		else begin
			failures++;
			$error("buf_valid high while the fifo is empty");
		end

	// offered word holds until the serializer takes it
	word_stable_until_taken: assert property (@(posedge clock) disable iff (reset1)
		(buf_valid && !buf_ready) |=> (buf_valid && $stable(buf_word)))
		else begin
			failures++;
			$error("buf_word changed or was withdrawn before it was taken");
		end

	// wrap flag only on a count zero word that follows a rollover
	wrap_flag_on_rollover: assert property (@(posedge clock) disable iff (reset1)
		rd_taken |-> (buf_word.seq_wrap == (zero_read && buf_word.data == '0)))
		else begin
			failures++;
			$error("seq_wrap does not match the rollover of the count");
		end

endmodule

`default_nettype wire

// File: verification/trigger_serdes_tb.sv
`default_nettype none

module trigger_serdes_tb import trigger_serdes_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_ROWS = 16; // short enable toggles
	localparam int DRAIN_MARGIN = (FIFO_DEPTH + 4) * WORD_WIDTH + 60; // final drain and slack

	typedef struct packed {
		logic en; // enable level for the row
		int unsigned hold; // cycles to keep it
	} stim_row_t;

	logic clock = 1'b0;
	logic reset1 = 1'b1; // asserted from time zero
	logic enable = 1'b1; // source runs from the start
	logic serial_out;
	logic frame_strobe;
	logic [WORD_WIDTH-1:0] led_byte;
	int value_errors;
	int protocol_errors;
	int words_seen;
	logic line_idle;

	stim_row_t stim_table [$];
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0; // table holds plus startup plus margin
	int tb_errors = 0;

	always #10 clock = ~clock;

	trigger_serdes_top dut0 (
		.clock(clock),
		.reset1(reset1),
		.enable(enable),
		.serial_out(serial_out),
		.frame_strobe(frame_strobe),
		.led_byte(led_byte)
	);

	stream_checker checker0 (
		.clock(clock),
		.reset1(reset1),
		.serial_out(serial_out),
		.frame_strobe(frame_strobe),
		.led_byte(led_byte),
		.words_waiting(dut0.buf_valid), // tells a real gap from an empty fifo
		.value_errors(value_errors),
		.protocol_errors(protocol_errors),
		.words_seen(words_seen),
		.line_idle(line_idle)
	);

	bind word_fifo trigger_serdes_asserts asserts0 (
		.clock(clock),
		.reset1(reset1),
		.src_valid(src_valid),
		.src_ready(src_ready),
		.buf_word(buf_word),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready)
	);

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_row(input logic en, input int unsigned hold);
		stim_row_t row;
		row.en = en;
		row.hold = hold;
		stim_table.push_back(row);
		cycle_limit += hold;
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int unsigned lcg_state;
		int assert_failures;
		lcg_state = 38;
		add_row(1'b1, 220); // startup, fifo fills, count wraps
		add_row(1'b0, 3); // short pause while the fifo is still backed up
		add_row(1'b1, 24);
		add_row(1'b0, 12);
		add_row(1'b1, 40);
		add_row(1'b0, 80); // drains the fifo, line goes idle
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			lcg_state = lcg_next(lcg_state);
			add_row(i % 2 == 0, 1 + (lcg_state >> 16) % 3); // 1 to 3 cycles
		end
		add_row(1'b1, 100);
		cycle_limit += RESET_CYCLES + STARTUP_CYCLES + DRAIN_MARGIN;
		repeat (RESET_CYCLES) @(posedge clock);
		reset1 <= 1'b0;
		foreach (stim_table[i]) begin
			enable <= stim_table[i].en;
			repeat (stim_table[i].hold) @(posedge clock);
		end
		enable <= 1'b0; // stop the source, let the path empty
		repeat (2) @(posedge clock);
		wait (line_idle);
		repeat (2 * WORD_WIDTH) @(posedge clock); // line has to stay quiet
		if (words_seen <= (1 << COUNT_WIDTH)) begin
			tb_errors++;
			$display("too few words on the line (%0d), the count never wrapped", words_seen);
		end
		assert_failures = dut0.fifo0.asserts0.failures;
		$display("value errors %0d, protocol errors %0d, assertion failures %0d, tb errors %0d",
			value_errors, protocol_errors, assert_failures, tb_errors);
		if (value_errors + protocol_errors + assert_failures + tb_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
